//--- st_io_top.f
st_io_pkg.sv
st_bus_pkg.sv
io_fifo.sv
io_regs.sv
mfp_clock_gen.sv
printer_port.sv
st_io_top.sv
st_io_checker.sv
tb_st_io_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ST I/O bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f st_io_top.f --top-module tb_st_io_top \
	-Mdir obj_dir -o sim_st_io
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_st_io > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
	exit 0
fi
echo "Simulation did not pass, see $LOG"
exit 1

//--- tb_st_io_top.sv
// Testbench for the ST I/O bridge
// Drives APB, FIFO write strobes and joysticks, checks the DUT
// against a behavioral model of the register map and port glue

`timescale 1ns/1ps

module tb_st_io_top
	import st_io_pkg::*, st_bus_pkg::*;
();

	localparam int          MIDI_DEPTH   = 16;
	localparam int          PAR_DEPTH    = 4;
	localparam logic [31:0] SYSTEM_CLOCK = 32'd32_084_988;
	localparam logic [31:0] MFP_CLOCK    = 32'd2_457_600;
	localparam int          MFP_CYCLES   = 20000;
	localparam int          TIMEOUT      = 30000; // All tests plus margin

	logic     clk_32;
	logic     reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     midi_out_strobe;
	byte_t    midi_out;
	logic     parallel_out_strobe;
	byte_t    parallel_out;
	joy_t     joy2;
	joy_t     joy3;
	ctrl_t    ctrl;
	logic     core_reset;
	logic     clk_mfp_en;
	logic     printer_busy;
	byte_t    parallel_in;
	logic     parallel_in_strobe;

	byte_t       midi_q[$];   // MIDI FIFO model
	byte_t       par_q[$];    // Printer FIFO model
	logic [31:0] model_ctrl;  // Control word model
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	logic        cmp_en = 1'b0;

	st_io_top #(
		.MIDI_DEPTH   (MIDI_DEPTH),
		.PAR_DEPTH    (PAR_DEPTH),
		.SYSTEM_CLOCK (SYSTEM_CLOCK),
		.MFP_CLOCK    (MFP_CLOCK)
	) i_dut (
		.clk_32 (clk_32), .reset (reset), .apb_req (apb_req), .apb_rsp (apb_rsp),
		.midi_out_strobe (midi_out_strobe), .midi_out (midi_out),
		.parallel_out_strobe (parallel_out_strobe), .parallel_out (parallel_out),
		.joy2 (joy2), .joy3 (joy3), .ctrl (ctrl), .core_reset (core_reset),
		.clk_mfp_en (clk_mfp_en), .printer_busy (printer_busy),
		.parallel_in (parallel_in), .parallel_in_strobe (parallel_in_strobe)
	);

	initial begin
		clk_32 = 1'b0;
		forever #50 clk_32 = ~clk_32; // 100 ns period
	end

	// Port input, joy2 directions on the high nibble, all inverted
	function automatic byte_t exp_parallel_in(joy_t j2, joy_t j3);
		byte_t p;
		int    k;
		for (k = 0; k < 4; k++) begin
			p[7 - k] = ~j2[k]; // joy_t bit 0 is right
			p[3 - k] = ~j3[k];
		end
		return p;
	endfunction

	function automatic logic exp_busy(logic [31:0] c, int par_cnt, joy_t j2);
		return (c[27:26] == 2'd2) ? (par_cnt == PAR_DEPTH) : j2.fire;
	endfunction

	function automatic logic [31:0] exp_status();
		logic [31:0] s;
		s    = '0;
		s[0] = (midi_q.size() != 0);
		s[1] = (par_q.size() != 0);
		s[2] = (par_q.size() == PAR_DEPTH);
		return s;
	endfunction

	// Enable pulses over n edges, accumulator starting at zero
	function automatic int exp_mfp_pulses(int n);
		longint gained;
		gained = longint'(n - 1) * longint'(MFP_CLOCK); // Phase added before the last edge
		return int'(gained / longint'(SYSTEM_CLOCK));   // One pulse per whole period
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s expected 0x%08h observed 0x%08h", name, exp, got);
		end
	endtask

	// Setup, access, then back to idle
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(posedge clk_32);
		apb_req.psel    <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= wr;
		apb_req.paddr   <= addr;
		apb_req.pwdata  <= wdata;
		@(posedge clk_32);
		apb_req.penable <= 1'b1;
		@(negedge clk_32); // Mid access phase
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		check_value("pready", 32'd1, {31'd0, apb_rsp.pready});
		@(posedge clk_32);
		apb_req <= '0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
		logic [31:0] rd;
		logic        err;
		apb_xfer(1'b1, addr, data, rd, err);
		check_value("pslverr", {31'd0, exp_err}, {31'd0, err});
		if (!exp_err && addr == REG_CTRL) begin
			model_ctrl = data;
			if (data[0]) begin // Core reset empties both FIFOs
				midi_q.delete();
				par_q.delete();
			end
		end
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp, input string name);
		logic [31:0] rd;
		logic        err;
		apb_xfer(1'b0, addr, 32'd0, rd, err);
		check_value("pslverr", 32'd0, {31'd0, err});
		check_value(name, exp, rd);
	endtask

	// Data register read, pops the model only when a byte waits
	task automatic read_fifo(input logic is_par);
		logic [31:0] exp;
		if (is_par) begin
			exp = (par_q.size() != 0) ? {24'd0, par_q[0]} : 32'd0;
			apb_read(REG_PAR_DATA, exp, "par_data");
			if (par_q.size() != 0) void'(par_q.pop_front());
		end else begin
			exp = (midi_q.size() != 0) ? {24'd0, midi_q[0]} : 32'd0;
			apb_read(REG_MIDI_DATA, exp, "midi_data");
			if (midi_q.size() != 0) void'(midi_q.pop_front());
		end
	endtask

	task automatic push_byte(input logic is_par, input byte_t b);
		@(posedge clk_32);
		if (is_par) begin
			parallel_out_strobe <= 1'b1;
			parallel_out        <= b;
		end else begin
			midi_out_strobe <= 1'b1;
			midi_out        <= b;
		end
		@(posedge clk_32); // FIFO takes the byte here
		parallel_out_strobe <= 1'b0;
		midi_out_strobe     <= 1'b0;
		if (!model_ctrl[0]) begin
			if (is_par && par_q.size() < PAR_DEPTH) par_q.push_back(b);
			if (!is_par && midi_q.size() < MIDI_DEPTH) midi_q.push_back(b);
		end
	endtask

	task automatic end_test(input int num, input string name, input int err_start);
		$display("test %0d %s done, %0d errors", num, name, errors - err_start);
	endtask

	// Compare process, outputs against the model every cycle
	always @(negedge clk_32) begin
		if (cmp_en) begin
			check_value("ctrl", model_ctrl, ctrl);
			check_value("core_reset", {31'd0, reset | model_ctrl[0]}, {31'd0, core_reset});
			check_value("printer_busy", {31'd0, exp_busy(model_ctrl, par_q.size(), joy2)},
				{31'd0, printer_busy});
			check_value("parallel_in", {24'd0, exp_parallel_in(joy2, joy3)},
				{24'd0, parallel_in});
			check_value("parallel_in_strobe", {31'd0, ~joy3.fire}, {31'd0, parallel_in_strobe});
		end
	end

	always @(posedge clk_32) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout after %0d cycles, the tests did not complete", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		logic [31:0] w;
		logic [31:0] rd;
		logic        err;
		int          err_start;
		int          pulses;
		int          i;
		void'($urandom(32'h41ea_6678));
		reset               = 1'b1;
		apb_req             = '0;
		midi_out_strobe     = 1'b0;
		midi_out            = '0;
		parallel_out_strobe = 1'b0;
		parallel_out        = '0;
		joy2                = '0;
		joy3                = '0;
		model_ctrl          = '0;
		repeat (16) @(posedge clk_32);
		reset <= 1'b0;
		@(posedge clk_32);
		cmp_en = 1'b1;

		err_start = errors; // Reset state
		apb_read(REG_CTRL, 32'd0, "ctrl_read");
		apb_read(REG_STATUS, 32'd0, "status");
		@(negedge clk_32);
		check_value("ctrl", 32'd0, ctrl);
		check_value("core_reset", 32'd0, {31'd0, core_reset});
		end_test(1, "reset values", err_start);

		err_start = errors; // Control word, core reset held
		push_byte(1'b0, 8'($urandom));
		push_byte(1'b1, 8'($urandom));
		w = $urandom | 32'd1;
		apb_write(REG_CTRL, w, 1'b0);
		apb_read(REG_CTRL, w, "ctrl_read");
		@(negedge clk_32);
		check_value("fdc_wp", {30'd0, w[7:6]}, {30'd0, ctrl.fdc_wp});
		check_value("scanlines", {30'd0, w[21:20]}, {30'd0, ctrl.scanlines});
		check_value("usb_redirection", {30'd0, w[27:26]}, {30'd0, ctrl.usb_redirection});
		check_value("blend", {31'd0, w[29]}, {31'd0, ctrl.blend});
		check_value("core_reset", 32'd1, {31'd0, core_reset});
		apb_read(REG_STATUS, 32'd0, "status");
		read_fifo(1'b0);
		read_fifo(1'b1);
		w[0] = 1'b0;
		apb_write(REG_CTRL, w, 1'b0);
		end_test(2, "control register", err_start);

		err_start = errors; // MIDI overflow and drain
		for (i = 0; i < MIDI_DEPTH + 3; i++) push_byte(1'b0, 8'($urandom));
		apb_read(REG_STATUS, exp_status(), "status");
		for (i = 0; i < MIDI_DEPTH + 1; i++) read_fifo(1'b0);
		apb_read(REG_STATUS, exp_status(), "status");
		end_test(3, "midi fifo", err_start);

		err_start = errors; // Printer busy source
		apb_write(REG_CTRL, 32'h0800_0000, 1'b0); // Redirect to printer
		for (i = 0; i < PAR_DEPTH; i++) push_byte(1'b1, 8'($urandom));
		@(negedge clk_32);
		check_value("printer_busy", 32'd1, {31'd0, printer_busy});
		apb_read(REG_STATUS, exp_status(), "status");
		read_fifo(1'b1);
		@(negedge clk_32);
		check_value("printer_busy", 32'd0, {31'd0, printer_busy});
		for (i = 0; i < 4; i++) begin
			if (i != 2) begin
				apb_write(REG_CTRL, 32'(i) << 26, 1'b0);
				@(posedge clk_32);
				joy2 <= joy_t'(5'b10000); // Fire only
				@(negedge clk_32);
				check_value("printer_busy", 32'd1, {31'd0, printer_busy});
				@(posedge clk_32);
				joy2 <= '0;
				@(negedge clk_32);
				check_value("printer_busy", 32'd0, {31'd0, printer_busy});
			end
		end
		end_test(4, "printer busy", err_start);

		err_start = errors; // Joystick mapping
		for (i = 0; i < 64; i++) begin
			@(posedge clk_32);
			joy2 <= joy_t'(5'($urandom));
			joy3 <= joy_t'(5'($urandom));
			@(negedge clk_32);
			check_value("parallel_in", {24'd0, exp_parallel_in(joy2, joy3)}, {24'd0, parallel_in});
			check_value("parallel_in_strobe", {31'd0, ~joy3.fire}, {31'd0, parallel_in_strobe});
		end
		end_test(5, "joystick mapping", err_start);

		err_start = errors; // Bus errors, then MFP rate
		apb_xfer(1'b0, 8'h10, 32'd0, rd, err);
		check_value("pslverr", 32'd1, {31'd0, err});
		apb_write(8'h20, $urandom, 1'b1);
		apb_write(REG_STATUS, 32'hffff_ffff, 1'b1);
		apb_write(REG_MIDI_DATA, 32'h0000_00a5, 1'b1);
		apb_write(REG_CTRL, 32'd1, 1'b0); // Restart the accumulator
		apb_write(REG_CTRL, 32'd0, 1'b0);
		pulses = 0;
		repeat (MFP_CYCLES) begin
			@(negedge clk_32);
			if (clk_mfp_en) pulses++;
		end
		// First sample still shows the reset edge
		check_value("clk_mfp_en pulses", exp_mfp_pulses(MFP_CYCLES - 1), pulses);
		end_test(6, "bus errors and mfp", err_start);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- st_io_checker.sv
// Protocol assertions for the ST I/O bridge
// Bound into the top level, watches APB ready, the MFP enable
// and the FIFO pop pulses

`timescale 1ns/1ps

module st_io_checker
	import st_bus_pkg::*;
(
	input logic     clk_32,
	input logic     reset,
	input apb_req_t apb_req,
	input apb_rsp_t apb_rsp,
	input logic     clk_mfp_en,
	input logic     midi_pop,
	input logic     midi_avail,
	input logic     par_pop,
	input logic     par_avail
);

	// Zero wait states
	a_pready: assert property (@(posedge clk_32) disable iff (reset)
		(apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
		else $error("pready low in an APB access phase");

	a_mfp_single: assert property (@(posedge clk_32) disable iff (reset)
		clk_mfp_en |=> !clk_mfp_en)
		else $error("clk_mfp_en high two cycles in a row");

	// Pops only with a byte waiting
	a_midi_pop: assert property (@(posedge clk_32) disable iff (reset)
		midi_pop |-> midi_avail)
		else $error("MIDI pop while the FIFO is empty");

	a_par_pop: assert property (@(posedge clk_32) disable iff (reset)
		par_pop |-> par_avail)
		else $error("printer pop while the FIFO is empty");

endmodule

bind st_io_top st_io_checker u_checker (
	.clk_32     (clk_32),
	.reset      (reset),
	.apb_req    (apb_req),
	.apb_rsp    (apb_rsp),
	.clk_mfp_en (clk_mfp_en),
	.midi_pop   (midi_pop),
	.midi_avail (midi_avail),
	.par_pop    (par_pop),
	.par_avail  (par_avail)
);

//--- st_io_top.sv
// ST I/O bridge top level
// APB register block, MIDI output FIFO, MFP clock enable
// and parallel port glue between the core and the I/O controller

`timescale 1ns/1ps

module st_io_top
	import st_io_pkg::*, st_bus_pkg::*;
#(
	parameter int          MIDI_DEPTH   = 16,
	parameter int          PAR_DEPTH    = 4,
	parameter logic [31:0] SYSTEM_CLOCK = 32'd32_084_988,
	parameter logic [31:0] MFP_CLOCK    = 32'd2_457_600
) (
	input  logic     clk_32,
	input  logic     reset,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	input  logic     midi_out_strobe,
	input  byte_t    midi_out,
	input  logic     parallel_out_strobe,
	input  byte_t    parallel_out,
	input  joy_t     joy2,
	input  joy_t     joy3,
	output ctrl_t    ctrl,
	output logic     core_reset,
	output logic     clk_mfp_en,
	output logic     printer_busy,
	output byte_t    parallel_in,
	output logic     parallel_in_strobe
);

	byte_t midi_head;
	logic  midi_avail;
	logic  midi_pop;
	byte_t par_head;
	logic  par_avail;
	logic  par_full;
	logic  par_pop;

	io_regs u_regs (
		.clk_32     (clk_32),
		.reset      (reset),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.midi_head  (midi_head),
		.midi_avail (midi_avail),
		.par_head   (par_head),
		.par_avail  (par_avail),
		.par_full   (par_full),
		.midi_pop   (midi_pop),
		.par_pop    (par_pop),
		.ctrl       (ctrl),
		.core_reset (core_reset)
	);

	// Filled on ACIA data writes
	io_fifo #(
		.DEPTH (MIDI_DEPTH)
	) u_midi_fifo (
		.clk_32 (clk_32),
		.reset  (core_reset),
		.wr     (midi_out_strobe),
		.din    (midi_out),
		.rd     (midi_pop),
		.dout   (midi_head),
		.avail  (midi_avail),
		.full   () // No MIDI full bit in the status word
	);

	mfp_clock_gen #(
		.SYSTEM_CLOCK (SYSTEM_CLOCK),
		.MFP_CLOCK    (MFP_CLOCK)
	) u_mfp_clk (
		.clk_32     (clk_32),
		.reset      (core_reset),
		.clk_mfp_en (clk_mfp_en)
	);

	printer_port #(
		.PAR_DEPTH (PAR_DEPTH)
	) u_printer (
		.clk_32              (clk_32),
		.reset               (core_reset),
		.parallel_out_strobe (parallel_out_strobe),
		.parallel_out        (parallel_out),
		.par_pop             (par_pop),
		.redirection         (ctrl.usb_redirection),
		.joy2                (joy2),
		.joy3                (joy3),
		.par_head            (par_head),
		.par_avail           (par_avail),
		.par_full            (par_full),
		.printer_busy        (printer_busy),
		.parallel_in         (parallel_in),
		.parallel_in_strobe  (parallel_in_strobe)
	);

endmodule

//--- printer_port.sv
// ST parallel port glue
// Buffers printer bytes for the I/O controller, picks the
// busy source and maps two extra joysticks onto the port input

`timescale 1ns/1ps

module printer_port
	import st_io_pkg::*;
#(
	parameter int PAR_DEPTH = 4
) (
	input  logic   clk_32,
	input  logic   reset,
	input  logic   parallel_out_strobe,
	input  byte_t  parallel_out,
	input  logic   par_pop,
	input  redir_t redirection,
	input  joy_t   joy2,
	input  joy_t   joy3,
	output byte_t  par_head,
	output logic   par_avail,
	output logic   par_full,
	output logic   printer_busy,
	output byte_t  parallel_in,
	output logic   parallel_in_strobe
);

	io_fifo #(
		.DEPTH (PAR_DEPTH)
	) u_par_fifo (
		.clk_32 (clk_32),
		.reset  (reset),
		.wr     (parallel_out_strobe), // CPU printer write
		.din    (parallel_out),
		.rd     (par_pop),
		.dout   (par_head),
		.avail  (par_avail),
		.full   (par_full)
	);

	// Busy from FIFO only when printing goes over USB
	assign printer_busy = (redirection == REDIR_PRINTER) ? par_full : joy2.fire;

	// Port lines are active low, joy2 on the upper nibble
	assign parallel_in = {~joy2.right, ~joy2.left, ~joy2.down, ~joy2.up,
		~joy3.right, ~joy3.left, ~joy3.down, ~joy3.up};
	assign parallel_in_strobe = ~joy3.fire; // joy3 fire on strobe

endmodule

//--- mfp_clock_gen.sv
// MFP timer clock enable
// Fractional accumulator turning the 32 MHz system clock
// into an average 2.4576 MHz single cycle enable

`timescale 1ns/1ps

module mfp_clock_gen #(
	parameter logic [31:0] SYSTEM_CLOCK = 32'd32_084_988,
	parameter logic [31:0] MFP_CLOCK    = 32'd2_457_600
) (
	input  logic clk_32,
	input  logic reset,
	output logic clk_mfp_en
);

	logic [31:0] acc; // Phase accumulator

	always_ff @(posedge clk_32) begin
		if (reset) begin
			acc        <= '0;
			clk_mfp_en <= 1'b0;
		end else if (acc < SYSTEM_CLOCK) begin
			acc        <= acc + MFP_CLOCK;
			clk_mfp_en <= 1'b0;
		end else begin
			// Wrapped, keep the remainder and tick once
			acc        <= acc - SYSTEM_CLOCK + MFP_CLOCK;
			clk_mfp_en <= 1'b1;
		end
	end

endmodule

//--- io_regs.sv
// APB register block of the ST I/O bridge
// Holds the system control word, reports FIFO status and
// hands MIDI and printer bytes to the I/O controller.
// Zero wait states, errors on unmapped or read-only writes

`timescale 1ns/1ps

module io_regs
	import st_io_pkg::*, st_bus_pkg::*;
(
	input  logic     clk_32,
	input  logic     reset,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	input  byte_t    midi_head,
	input  logic     midi_avail,
	input  byte_t    par_head,
	input  logic     par_avail,
	input  logic     par_full,
	output logic     midi_pop,
	output logic     par_pop,
	output ctrl_t    ctrl,
	output logic     core_reset
);

	logic        access;    // APB access phase
	logic        rd_access;
	logic        wr_access;
	logic        addr_ok;   // Offset is mapped
	logic        addr_ro;   // Offset refuses writes
	logic        ctrl_wr;
	logic [31:0] status_word;
	logic [31:0] rd_data;

	assign access    = apb_req.psel & apb_req.penable;
	assign rd_access = access & ~apb_req.pwrite;
	assign wr_access = access & apb_req.pwrite;

	// Offset decode
	always_comb begin
		addr_ok = 1'b1;
		addr_ro = 1'b1;
		case (apb_req.paddr)
			REG_CTRL:      addr_ro = 1'b0;
			REG_STATUS:    addr_ro = 1'b1;
			REG_MIDI_DATA: addr_ro = 1'b1;
			REG_PAR_DATA:  addr_ro = 1'b1;
			default:       addr_ok = 1'b0; // Unmapped
		endcase
	end

	always_comb begin
		status_word                  = '0;
		status_word[STAT_MIDI_AVAIL] = midi_avail;
		status_word[STAT_PAR_AVAIL]  = par_avail;
		status_word[STAT_PAR_FULL]   = par_full;
	end

	// Read mux, empty FIFO reads back as zero
	always_comb begin
		rd_data = '0;
		case (apb_req.paddr)
			REG_CTRL:      rd_data = ctrl;
			REG_STATUS:    rd_data = status_word;
			REG_MIDI_DATA: rd_data = midi_avail ? {24'd0, midi_head} : 32'd0;
			REG_PAR_DATA:  rd_data = par_avail ? {24'd0, par_head} : 32'd0;
			default:       rd_data = '0;
		endcase
	end

	always_comb begin
		apb_rsp.prdata  = rd_access ? rd_data : 32'd0;
		apb_rsp.pready  = access;                 // No wait states
		apb_rsp.pslverr = access & (~addr_ok | (apb_req.pwrite & addr_ro));
	end

	// One pop per data read, only with a byte waiting
	assign midi_pop = rd_access & (apb_req.paddr == REG_MIDI_DATA) & midi_avail;
	assign par_pop  = rd_access & (apb_req.paddr == REG_PAR_DATA) & par_avail;

	assign ctrl_wr = wr_access & (apb_req.paddr == REG_CTRL);

	// Control word, reserved bits kept as written
	always_ff @(posedge clk_32) begin
		if (reset) begin
			ctrl <= '0;
		end else if (ctrl_wr) begin
			ctrl <= ctrl_t'(apb_req.pwdata);
		end
	end

	// Core held in reset by the pin or by the controller
	assign core_reset = reset | ctrl.core_reset;

endmodule

//--- io_fifo.sv
// Byte FIFO between the ST core and the I/O controller
// First word fall through, head byte shown while avail is high.
// Writes into a full FIFO and reads from an empty one are ignored

`timescale 1ns/1ps

module io_fifo
	import st_io_pkg::*;
#(
	parameter int DEPTH = 16
) (
	input  logic  clk_32,
	input  logic  reset,
	input  logic  wr,
	input  byte_t din,
	input  logic  rd,
	output byte_t dout,
	output logic  avail,
	output logic  full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	byte_t            mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr;
	logic             do_rd;

	assign full  = (count == CNT_W'(DEPTH));
	assign avail = (count != '0);
	assign do_wr = wr & ~full;   // Drop when full
	assign do_rd = rd & avail;
	assign dout  = mem[rd_ptr];  // Head byte

	// Storage, no reset needed
	always_ff @(posedge clk_32) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk_32) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or none
			endcase
		end
	end

endmodule

//--- st_bus_pkg.sv
// APB view of the ST I/O bridge
// Request and response bundles plus the register map
// used by the I/O controller side

package st_bus_pkg;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// Register offsets
	localparam logic [7:0] REG_CTRL      = 8'h00; // Read and write
	localparam logic [7:0] REG_STATUS    = 8'h04; // Read only
	localparam logic [7:0] REG_MIDI_DATA = 8'h08; // Read pops MIDI byte
	localparam logic [7:0] REG_PAR_DATA  = 8'h0C; // Read pops printer byte

	// Status word bits
	localparam int STAT_MIDI_AVAIL = 0;
	localparam int STAT_PAR_AVAIL  = 1;
	localparam int STAT_PAR_FULL   = 2;

endpackage

//--- st_io_pkg.sv
// ST I/O bridge, core side definitions
// Control register layout as sent by the I/O controller,
// redirection codes and the extra joystick bit order

package st_io_pkg;

	typedef logic [7:0] byte_t;

	// USB target port on the I/O controller
	typedef enum logic [1:0] {
		REDIR_NONE    = 2'd0,
		REDIR_RS232   = 2'd1,
		REDIR_PRINTER = 2'd2,
		REDIR_MIDI    = 2'd3
	} redir_t;

	// 32 bit system control word, bit 31 first
	typedef struct packed {
		logic [1:0]  rsv_31_30;
		logic        blend;           // Bit 29 video blend
		logic        rsv_28;
		redir_t      usb_redirection; // Bits 27:26
		logic [3:0]  rsv_25_22;
		logic [1:0]  scanlines;       // Bits 21:20
		logic [11:0] rsv_19_8;
		logic [1:0]  fdc_wp;          // Bits 7:6 per drive
		logic [4:0]  rsv_5_1;
		logic        core_reset;      // Bit 0
	} ctrl_t;

	// Gauntlet style joystick, all active high
	typedef struct packed {
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

endpackage
